// ==== Bender.yml ====
package:
  name: fp_add_unit

sources:
  - include_dirs:
      - logic
    files:
      - logic/fp_format_pkg.sv
      - logic/fp_op_pkg.sv
      - logic/fp_operand_align.sv
      - logic/fp_mant_adder.sv
      - logic/fp_add_writeback.sv
      - logic/fp_add_unit.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tb/fp_add_unit_props.sv
      - tb/fp_add_unit_tb.sv

// ==== build.f ====
+incdir+logic
logic/fp_format_pkg.sv
logic/fp_op_pkg.sv
logic/fp_operand_align.sv
logic/fp_mant_adder.sv
logic/fp_add_writeback.sv
logic/fp_add_unit.sv
tb/fp_add_unit_props.sv
tb/fp_add_unit_tb.sv

// ==== logic/fp_add_macros.svh ====
// ##########################################################
// width, tag and constant macros for the fp add/sub unit
// ##########################################################
`ifndef FP_ADD_MACROS_SVH
`define FP_ADD_MACROS_SVH

// single precision field widths
`define FP_EXPO_WIDTH 8
`define FP_FRAC_WIDTH 23

// guard, round and sticky
`define FP_GRS_WIDTH 3

// issue tag width
`define FP_ID_WIDTH 4

// quiet nan returned for every nan result
`define FP_CANONICAL_NAN 32'h7fc0_0000

// shift distance from which the smaller operand only feeds sticky
// mantissa width plus guard and round
`define FP_ALIGN_LIMIT 26

`endif

// ==== logic/fp_add_unit.sv ====
// ##########################################################
// fp add/sub unit top: align, add and writeback chain
// ##########################################################
`timescale 1ns/1ps

module fp_add_unit
  import fp_format_pkg::*;
  import fp_op_pkg::*;
(
  input  logic     clk,
  input  logic     arst_n,
  input  logic     issue_valid,
  output logic     issue_ready,
  input  fp_op_t   issue_op,
  input  rm_t      issue_rm,
  input  id_t      issue_id,
  input  fp_word_t issue_rs1,
  input  fp_word_t issue_rs2,
  output logic     wb_done,
  input  logic     wb_ack,
  output id_t      wb_id,
  output rm_t      wb_rm,
  output fp_word_t wb_rd,
  output grs_t     wb_grs,
  output logic     wb_carry,
  output logic     wb_hidden,
  output clz_t     wb_clz,
  output logic     wb_invalid
);

  // stage 1 fields
  logic  s1_valid, s1_advance;
  id_t   s1_id;
  rm_t   s1_rm;
  logic  s1_big_sign, s1_subtract, s1_expo_equal;
  expo_t s1_big_expo;
  mant_t s1_big_mant, s1_small_aligned;
  grs_t  s1_small_grs;
  logic  s1_result_nan, s1_result_inf, s1_inf_sign, s1_invalid;

  // stage 2 fields
  logic  s2_valid, s2_advance;
  id_t   s2_id;
  rm_t   s2_rm;
  logic  s2_sign;
  expo_t s2_expo;
  sum_t  s2_sum;
  grs_t  s2_grs;
  logic  s2_result_nan, s2_result_inf, s2_inf_sign, s2_invalid;

  // accept whenever stage 1 can move
  assign issue_ready = s1_advance;

  fp_operand_align align_i (.*);

  fp_mant_adder adder_i (.*);

  fp_add_writeback writeback_i (.*);

endmodule

// ==== logic/fp_add_writeback.sv ====
// ##########################################################
// writeback: leading zero count, special results, done/ack
// ##########################################################
`timescale 1ns/1ps
`include "fp_add_macros.svh"

module fp_add_writeback
  import fp_format_pkg::*;
  import fp_op_pkg::*;
(
  input  logic     s2_valid,
  input  id_t      s2_id,
  input  rm_t      s2_rm,
  input  logic     s2_sign,
  input  expo_t    s2_expo,
  input  sum_t     s2_sum,
  input  grs_t     s2_grs,
  input  logic     s2_result_nan,
  input  logic     s2_result_inf,
  input  logic     s2_inf_sign,
  input  logic     s2_invalid,
  input  logic     wb_ack,
  output logic     s2_advance,
  output logic     wb_done,
  output id_t      wb_id,
  output rm_t      wb_rm,
  output fp_word_t wb_rd,
  output grs_t     wb_grs,
  output logic     wb_carry,
  output logic     wb_hidden,
  output clz_t     wb_clz,
  output logic     wb_invalid
);

  clz_t clz;

  // stage 2 register is the output register
  assign wb_done    = s2_valid;
  assign s2_advance = ~s2_valid | wb_ack;

  // highest set bit below the carry wins, 24 when all clear
  always_comb begin
    clz = 5'd24;
    for (int i = 0; i <= `FP_FRAC_WIDTH; i++) begin
      if (s2_sum[i]) begin
        clz = 5'(`FP_FRAC_WIDTH - i);
      end
    end
  end

  // nan beats infinity, both override the sum
  always_comb begin
    if (s2_result_nan) begin
      wb_rd = `FP_CANONICAL_NAN;
    end else if (s2_result_inf) begin
      wb_rd = {s2_inf_sign, {`FP_EXPO_WIDTH{1'b1}}, {`FP_FRAC_WIDTH{1'b0}}};
    end else begin
      wb_rd = {s2_sign, s2_expo, s2_sum[`FP_FRAC_WIDTH-1:0]};
    end
  end

  // fields for the external normalizer and rounder
  assign wb_id      = s2_id;
  assign wb_rm      = s2_rm;
  assign wb_grs     = s2_grs;
  assign wb_carry   = s2_sum[`FP_FRAC_WIDTH+1];
  assign wb_hidden  = s2_sum[`FP_FRAC_WIDTH];
  assign wb_clz     = clz;
  assign wb_invalid = s2_invalid;

endmodule

// ==== logic/fp_format_pkg.sv ====
// ##########################################################
// number format types: word, fields and adder intermediates
// ##########################################################
`include "fp_add_macros.svh"

package fp_format_pkg;

  // packed sign, exponent, fraction
  typedef logic [`FP_EXPO_WIDTH+`FP_FRAC_WIDTH:0] fp_word_t;

  // biased exponent
  typedef logic [`FP_EXPO_WIDTH-1:0] expo_t;

  // stored fraction, no hidden bit
  typedef logic [`FP_FRAC_WIDTH-1:0] frac_t;

  // hidden bit on top of the fraction
  typedef logic [`FP_FRAC_WIDTH:0] mant_t;

  // guard, round, sticky in that order
  typedef logic [`FP_GRS_WIDTH-1:0] grs_t;

  // carry bit above the mantissa
  typedef logic [`FP_FRAC_WIDTH+1:0] sum_t;

  // left shift for the normalizer, 0..24
  typedef logic [4:0] clz_t;

endpackage

// ==== logic/fp_mant_adder.sv ====
// ##########################################################
// stage 2: ones-complement add/sub, sign and zero, register
// ##########################################################
`timescale 1ns/1ps
`include "fp_add_macros.svh"

module fp_mant_adder
  import fp_format_pkg::*;
  import fp_op_pkg::*;
(
  input  logic  clk,
  input  logic  arst_n,
  input  logic  s1_valid,
  input  id_t   s1_id,
  input  rm_t   s1_rm,
  input  logic  s1_big_sign,
  input  expo_t s1_big_expo,
  input  mant_t s1_big_mant,
  input  mant_t s1_small_aligned,
  input  grs_t  s1_small_grs,
  input  logic  s1_subtract,
  input  logic  s1_expo_equal,
  input  logic  s1_result_nan,
  input  logic  s1_result_inf,
  input  logic  s1_inf_sign,
  input  logic  s1_invalid,
  input  logic  s2_advance,
  output logic  s1_advance,
  output logic  s2_valid,
  output id_t   s2_id,
  output rm_t   s2_rm,
  output logic  s2_sign,
  output expo_t s2_expo,
  output sum_t  s2_sum,
  output grs_t  s2_grs,
  output logic  s2_result_nan,
  output logic  s2_result_inf,
  output logic  s2_inf_sign,
  output logic  s2_invalid
);

  // carry, mantissa, grs
  localparam int ADD_W = 1 + `FP_FRAC_WIDTH + 1 + `FP_GRS_WIDTH;

  logic [ADD_W-1:0] op_a, op_b, op_b_inv, mag;
  logic [ADD_W:0]   raw;
  logic             negative;
  logic             zero_diff;
  logic             sign;
  expo_t            expo;

  // stage 1 moves when empty or when stage 2 makes room
  assign s1_advance = ~s1_valid | s2_advance;

  assign op_a     = {1'b0, s1_big_mant, {`FP_GRS_WIDTH{1'b0}}};
  assign op_b     = {1'b0, s1_small_aligned, s1_small_grs};
  assign op_b_inv = s1_subtract ? ~op_b : op_b;
  assign raw      = {1'b0, op_a} + {1'b0, op_b_inv};

  // no carry out on a subtract means b was at least a
  assign negative = s1_subtract & ~raw[ADD_W];

  always_comb begin
    if (!s1_subtract) begin
      mag = raw[ADD_W-1:0];
    end else if (raw[ADD_W]) begin
      // end-around carry
      mag = raw[ADD_W-1:0] + 1'b1;
    end else begin
      // complement gives b - a directly
      mag = ~raw[ADD_W-1:0];
    end
  end

  // exact cancellation, sign from rounding mode
  assign zero_diff = s1_subtract & s1_expo_equal & (mag == '0);
  assign sign      = zero_diff ? (s1_rm == RM_RDN) : (s1_big_sign ^ negative);
  assign expo      = zero_diff ? '0 : s1_big_expo;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      s2_valid <= 1'b0;
    end else if (s2_advance) begin
      s2_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (s2_advance) begin
      s2_id         <= s1_id;
      s2_rm         <= s1_rm;
      s2_sign       <= sign;
      s2_expo       <= expo;
      s2_sum        <= mag[ADD_W-1:`FP_GRS_WIDTH];
      s2_grs        <= mag[`FP_GRS_WIDTH-1:0];
      s2_result_nan <= s1_result_nan;
      s2_result_inf <= s1_result_inf;
      s2_inf_sign   <= s1_inf_sign;
      s2_invalid    <= s1_invalid;
    end
  end

endmodule

// ==== logic/fp_op_pkg.sv ====
// ##########################################################
// operation types: opcode, rounding mode, tag, operand class
// ##########################################################
`include "fp_add_macros.svh"

package fp_op_pkg;

  // add or subtract
  typedef enum logic {
    FADD = 1'b0,
    FSUB = 1'b1
  } fp_op_t;

  // riscv style rounding mode field
  typedef logic [2:0] rm_t;

  // round toward minus infinity
  localparam rm_t RM_RDN = 3'd2;

  // issue tag, returned with the result
  typedef logic [`FP_ID_WIDTH-1:0] id_t;

  // zero and subnormal count as normal here
  typedef enum logic [1:0] {
    CLASS_NORMAL,
    CLASS_INF,
    CLASS_QNAN,
    CLASS_SNAN
  } fp_class_t;

endpackage

// ==== logic/fp_operand_align.sv ====
// ##########################################################
// stage 1: unpack, classify, swap and align, with register
// ##########################################################
`timescale 1ns/1ps
`include "fp_add_macros.svh"

module fp_operand_align
  import fp_format_pkg::*;
  import fp_op_pkg::*;
(
  input  logic     clk,
  input  logic     arst_n,
  input  logic     issue_valid,
  input  fp_op_t   issue_op,
  input  rm_t      issue_rm,
  input  id_t      issue_id,
  input  fp_word_t issue_rs1,
  input  fp_word_t issue_rs2,
  input  logic     s1_advance,
  output logic     s1_valid,
  output id_t      s1_id,
  output rm_t      s1_rm,
  output logic     s1_big_sign,
  output expo_t    s1_big_expo,
  output mant_t    s1_big_mant,
  output mant_t    s1_small_aligned,
  output grs_t     s1_small_grs,
  output logic     s1_subtract,
  output logic     s1_expo_equal,
  output logic     s1_result_nan,
  output logic     s1_result_inf,
  output logic     s1_inf_sign,
  output logic     s1_invalid
);

  localparam int MANT_W  = `FP_FRAC_WIDTH + 1;
  localparam int SHIFT_W = MANT_W + `FP_ALIGN_LIMIT;

  logic      sign_a, sign_b;
  expo_t     expo_a, expo_b;
  frac_t     frac_a, frac_b;
  mant_t     mant_a, mant_b;
  fp_class_t class_a, class_b;
  logic      inf_a, inf_b, nan_a, nan_b, snan_a, snan_b;
  logic      swap;
  logic      big_sign;
  expo_t     big_expo, small_expo, expo_diff;
  mant_t     big_mant, small_mant, small_aligned;
  logic      far_shift;
  logic [SHIFT_W-1:0] shifted;
  grs_t      small_grs;
  logic      invalid, result_nan, result_inf, inf_sign;

  // exponent all ones marks inf or nan, fraction msb marks quiet
  function automatic fp_class_t classify(input expo_t expo, input frac_t frac);
    fp_class_t cls;
    if (expo != '1) begin
      cls = CLASS_NORMAL;
    end else if (frac == '0) begin
      cls = CLASS_INF;
    end else if (frac[`FP_FRAC_WIDTH-1]) begin
      cls = CLASS_QNAN;
    end else begin
      cls = CLASS_SNAN;
    end
    return cls;
  endfunction

  // unpack, subtract flips the second sign
  assign sign_a = issue_rs1[`FP_EXPO_WIDTH+`FP_FRAC_WIDTH];
  assign sign_b = issue_rs2[`FP_EXPO_WIDTH+`FP_FRAC_WIDTH] ^ (issue_op == FSUB);
  assign expo_a = issue_rs1[`FP_FRAC_WIDTH +: `FP_EXPO_WIDTH];
  assign expo_b = issue_rs2[`FP_FRAC_WIDTH +: `FP_EXPO_WIDTH];
  assign frac_a = issue_rs1[`FP_FRAC_WIDTH-1:0];
  assign frac_b = issue_rs2[`FP_FRAC_WIDTH-1:0];

  // subnormals get hidden bit 0, exponent field kept as is
  assign mant_a = {expo_a != '0, frac_a};
  assign mant_b = {expo_b != '0, frac_b};

  assign class_a = classify(expo_a, frac_a);
  assign class_b = classify(expo_b, frac_b);
  assign inf_a   = class_a == CLASS_INF;
  assign inf_b   = class_b == CLASS_INF;
  assign snan_a  = class_a == CLASS_SNAN;
  assign snan_b  = class_b == CLASS_SNAN;
  assign nan_a   = snan_a | (class_a == CLASS_QNAN);
  assign nan_b   = snan_b | (class_b == CLASS_QNAN);

  // signalling nan, or infinities cancelling each other
  assign invalid    = snan_a | snan_b | (inf_a & inf_b & (sign_a ^ sign_b));
  assign result_nan = nan_a | nan_b | invalid;
  assign result_inf = (inf_a | inf_b) & ~result_nan;
  assign inf_sign   = inf_a ? sign_a : sign_b;

  // larger exponent goes first
  assign swap       = expo_b > expo_a;
  assign big_sign   = swap ? sign_b : sign_a;
  assign big_expo   = swap ? expo_b : expo_a;
  assign big_mant   = swap ? mant_b : mant_a;
  assign small_expo = swap ? expo_a : expo_b;
  assign small_mant = swap ? mant_a : mant_b;
  assign expo_diff  = big_expo - small_expo;
  assign far_shift  = expo_diff >= `FP_ALIGN_LIMIT;

  // below the limit nothing falls off the low end of this vector
  assign shifted = {small_mant, {`FP_ALIGN_LIMIT{1'b0}}} >> expo_diff;

  always_comb begin
    if (far_shift) begin
      // whole operand collapses into sticky
      small_aligned = '0;
      small_grs     = {2'b00, |small_mant};
    end else begin
      small_aligned = shifted[SHIFT_W-1 -: MANT_W];
      small_grs     = {shifted[`FP_ALIGN_LIMIT-1],
                       shifted[`FP_ALIGN_LIMIT-2],
                       |shifted[`FP_ALIGN_LIMIT-3:0]};
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      s1_valid <= 1'b0;
    end else if (s1_advance) begin
      s1_valid <= issue_valid;
    end
  end

  // payload follows the valid bit
  always_ff @(posedge clk) begin
    if (s1_advance) begin
      s1_id            <= issue_id;
      s1_rm            <= issue_rm;
      s1_big_sign      <= big_sign;
      s1_big_expo      <= big_expo;
      s1_big_mant      <= big_mant;
      s1_small_aligned <= small_aligned;
      s1_small_grs     <= small_grs;
      s1_subtract      <= sign_a ^ sign_b;
      s1_expo_equal    <= expo_a == expo_b;
      s1_result_nan    <= result_nan;
      s1_result_inf    <= result_inf;
      s1_inf_sign      <= inf_sign;
      s1_invalid       <= invalid;
    end
  end

endmodule

// ==== tb/fp_add_unit_props.sv ====
// ##########################################################
// bound handshake assertions for the fp add/sub unit
// ##########################################################
`timescale 1ns/1ps

module fp_add_unit_props
  import fp_format_pkg::*;
  import fp_op_pkg::*;
(
  input logic     clk,
  input logic     arst_n,
  input logic     issue_valid,
  input logic     issue_ready,
  input logic     wb_done,
  input logic     wb_ack,
  input id_t      wb_id,
  input rm_t      wb_rm,
  input fp_word_t wb_rd,
  input grs_t     wb_grs,
  input logic     wb_carry,
  input logic     wb_hidden,
  input clz_t     wb_clz,
  input logic     wb_invalid
);

  // accepted but not yet written back
  logic [2:0] in_flight;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      in_flight <= '0;
    end else begin
      in_flight <= in_flight + (issue_valid & issue_ready) - (wb_done & wb_ack);
    end
  end

  // result held while waiting for ack
  hold_stable: assert property (@(posedge clk) disable iff (!arst_n)
    wb_done && !wb_ack |=> wb_done && $stable(wb_rd) && $stable(wb_id) && $stable(wb_rm)
      && $stable(wb_grs) && $stable(wb_carry) && $stable(wb_hidden) && $stable(wb_clz)
      && $stable(wb_invalid))
    else $error("wb outputs changed while done was waiting for ack");

  // first cycle out of reset
  reset_state: assert property (@(posedge clk) $rose(arst_n) |-> issue_ready && !wb_done)
    else $error("unit not idle right after reset");

  // done only with something in flight
  done_needs_issue: assert property (@(posedge clk) disable iff (!arst_n)
    wb_done |-> in_flight != 0)
    else $error("wb_done without an accepted issue");

endmodule

// ==== tb/fp_add_unit_tb.sv ====
// ##########################################################
// testbench with lfsr stimulus, reference model and checks
// ##########################################################
`timescale 1ns/1ps
`include "fp_add_macros.svh"

module fp_add_unit_tb;
  import fp_format_pkg::*;
  import fp_op_pkg::*;

  localparam int NUM_TESTS = 2000;

  typedef struct packed {
    fp_word_t rd;
    grs_t     grs;
    logic     carry;
    logic     hidden;
    clz_t     clz;
    logic     invalid;
    logic     special;
    id_t      id;
    rm_t      rm;
  } expect_t;

  logic     clk, arst_n, issue_valid, issue_ready, wb_done, wb_ack;
  fp_op_t   issue_op;
  rm_t      issue_rm, wb_rm;
  id_t      issue_id, wb_id;
  fp_word_t issue_rs1, issue_rs2, wb_rd;
  grs_t     wb_grs;
  logic     wb_carry, wb_hidden, wb_invalid;
  clz_t     wb_clz;

  logic [31:0] lfsr_state;
  expect_t     expected_q[$];
  int          accepted;
  int          delivered;

  fp_add_unit dut_i (.*);

  bind fp_add_unit fp_add_unit_props props_i (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic fail_run();
    $display("Test failed");
    $fatal(1, "stopped at first error");
  endtask

  // one compare per result kind
  task automatic compare_word(input string what, input fp_word_t exp_v, input fp_word_t act_v);
    if (act_v !== exp_v) begin
      $display("ERR %s: expected %h, actual %h", what, exp_v, act_v);
      fail_run();
    end
  endtask

  task automatic compare_grs(input string what, input grs_t exp_v, input grs_t act_v);
    if (act_v !== exp_v) begin
      $display("ERR %s: expected %b, actual %b", what, exp_v, act_v);
      fail_run();
    end
  endtask

  task automatic compare_clz(input string what, input clz_t exp_v, input clz_t act_v);
    if (act_v !== exp_v) begin
      $display("ERR %s: expected %0d, actual %0d", what, exp_v, act_v);
      fail_run();
    end
  endtask

  task automatic compare_bit(input string what, input logic exp_v, input logic act_v);
    if (act_v !== exp_v) begin
      $display("ERR %s: expected %b, actual %b", what, exp_v, act_v);
      fail_run();
    end
  endtask

  task automatic compare_id(input string what, input id_t exp_v, input id_t act_v);
    if (act_v !== exp_v) begin
      $display("ERR %s: expected %0d, actual %0d", what, exp_v, act_v);
      fail_run();
    end
  endtask

  task automatic compare_rm(input string what, input rm_t exp_v, input rm_t act_v);
    if (act_v !== exp_v) begin
      $display("ERR %s: expected %0d, actual %0d", what, exp_v, act_v);
      fail_run();
    end
  endtask

  // fibonacci lfsr on taps 32 22 2 1 stepped once per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] bits;
    logic        fb;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      bits       = {bits[30:0], fb};
    end
    return bits;
  endfunction

  // operand biased toward specials and exponents near the other one
  function automatic fp_word_t make_operand(input logic [3:0] sel, input fp_word_t other);
    logic  sign;
    frac_t frac;
    int    e;
    sign = take_bits(1) != 0;
    frac = frac_t'(take_bits(23));
    e    = other[30:23];
    case (sel)
      4'd0: return {sign, 8'h00, 23'd0};
      4'd1: return {sign, 8'hff, 23'd0};
      4'd2: return {sign, 8'hff, frac | 23'h40_0000};
      4'd3: return {sign, 8'hff, (frac & 23'h3f_ffff) | 23'd1};
      4'd4: return {sign, 8'h00, frac};
      4'd5, 4'd6: return {sign, other[30:0]};
      4'd7, 4'd8, 4'd9: e = e + int'(take_bits(3)) - 4;
      4'd10, 4'd11: begin
        // around and past the alignment limit
        if (take_bits(1) != 0) e = e + 20 + int'(take_bits(4));
        else e = e - 20 - int'(take_bits(4));
      end
      default: e = int'(take_bits(8));
    endcase
    if (e < 1) e = 1;
    if (e > 254) e = 254;
    return {sign, expo_t'(e), frac};
  endfunction

  // result from the add/sub rules with specials first
  function automatic expect_t model_result(input fp_op_t op, input rm_t rm, input id_t id,
                                           input fp_word_t rs1, input fp_word_t rs2);
    expect_t     r;
    logic        sa, sb, inf_a, inf_b, nan_a, nan_b, snan_a, snan_b, nan;
    logic        big_s, neg, zero, found, g, rnd, st;
    expo_t       ea, eb, big_e;
    mant_t       ma, mb, big_m, small_m;
    int          diff;
    logic [27:0] big_x, small_x, mag;
    sum_t        sum;
    sa     = rs1[31];
    sb     = rs2[31] ^ (op == FSUB);
    ea     = rs1[30:23];
    eb     = rs2[30:23];
    ma     = {ea != 0, rs1[22:0]};
    mb     = {eb != 0, rs2[22:0]};
    inf_a  = ea == 8'hff && rs1[22:0] == 0;
    inf_b  = eb == 8'hff && rs2[22:0] == 0;
    nan_a  = ea == 8'hff && !inf_a;
    nan_b  = eb == 8'hff && !inf_b;
    snan_a = nan_a && !rs1[22];
    snan_b = nan_b && !rs2[22];
    r           = '0;
    r.id        = id;
    r.rm        = rm;
    r.invalid   = snan_a | snan_b | (inf_a & inf_b & (sa != sb));
    nan         = nan_a | nan_b | r.invalid;
    r.special   = nan | inf_a | inf_b;
    // bigger exponent first and a wins ties
    if (eb > ea) begin
      big_s   = sb;
      big_e   = eb;
      big_m   = mb;
      small_m = ma;
    end else begin
      big_s   = sa;
      big_e   = ea;
      big_m   = ma;
      small_m = mb;
    end
    diff = (eb > ea) ? int'(eb) - int'(ea) : int'(ea) - int'(eb);
    g = 1'b0;
    rnd = 1'b0;
    st = 1'b0;
    for (int i = 0; i < 24; i++) begin
      if (small_m[i]) begin
        if (i == diff - 1) g = 1'b1;
        else if (i == diff - 2) rnd = 1'b1;
        else if (i < diff - 2) st = 1'b1;
      end
    end
    big_x   = {1'b0, big_m, 3'b000};
    small_x = {1'b0, mant_t'(small_m >> diff), g, rnd, st};
    neg     = 1'b0;
    if (sa == sb) mag = big_x + small_x;
    else if (small_x > big_x) begin
      mag = small_x - big_x;
      neg = 1'b1;
    end else mag = big_x - small_x;
    zero     = sa != sb && ea == eb && mag == 0;
    sum      = mag[27:3];
    r.grs    = mag[2:0];
    r.carry  = sum[24];
    r.hidden = sum[23];
    // leading zeros below the carry
    found = 1'b0;
    for (int i = 23; i >= 0; i--) begin
      if (!found && sum[i]) found = 1'b1;
      else if (!found) r.clz = r.clz + 1'b1;
    end
    if (nan) r.rd = `FP_CANONICAL_NAN;
    else if (inf_a | inf_b) r.rd = {inf_a ? sa : sb, 8'hff, 23'd0};
    else r.rd = {zero ? rm == 3'd2 : big_s ^ neg, zero ? 8'h00 : big_e, sum[22:0]};
    return r;
  endfunction

  task automatic check_writeback();
    expect_t e;
    string   name;
    if (expected_q.size() == 0) begin
      $display("writeback transfer with no accepted item pending");
      fail_run();
    end
    e    = expected_q.pop_front();
    name = $sformatf("result %0d", delivered);
    compare_id({name, " id"}, e.id, wb_id);
    compare_rm({name, " rm"}, e.rm, wb_rm);
    compare_word({name, " rd"}, e.rd, wb_rd);
    compare_bit({name, " invalid"}, e.invalid, wb_invalid);
    // normalizer fields only matter for ordinary results
    if (!e.special) begin
      compare_grs({name, " grs"}, e.grs, wb_grs);
      compare_bit({name, " carry"}, e.carry, wb_carry);
      compare_bit({name, " hidden"}, e.hidden, wb_hidden);
      compare_clz({name, " clz"}, e.clz, wb_clz);
    end
    delivered++;
  endtask

  // transfers sampled at the edge before any register update
  always @(posedge clk) begin
    if (arst_n) begin
      if (wb_done && wb_ack) check_writeback();
      if (issue_valid && issue_ready) begin
        expected_q.push_back(model_result(issue_op, issue_rm, issue_id, issue_rs1, issue_rs2));
        accepted++;
      end
    end
  end

  initial begin
    repeat (NUM_TESTS * 40) @(posedge clk);
    $display("timeout: %0d of %0d results written back", delivered, NUM_TESTS);
    fail_run();
  end

  initial begin
    fp_word_t a, b;
    lfsr_state  = 32'h66d3;
    accepted    = 0;
    delivered   = 0;
    arst_n      = 1'b0;
    issue_valid = 1'b0;
    issue_op    = FADD;
    issue_rm    = '0;
    issue_id    = '0;
    issue_rs1   = '0;
    issue_rs2   = '0;
    wb_ack      = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    while (delivered < NUM_TESTS) begin
      @(negedge clk);
      issue_valid = accepted < NUM_TESTS && take_bits(2) != 0;
      issue_op    = take_bits(1) != 0 ? FSUB : FADD;
      issue_rm    = rm_t'(take_bits(3));
      issue_id    = id_t'(accepted);
      a           = make_operand(4'(take_bits(4)), {1'b0, 8'd127, 23'd0});
      b           = make_operand(4'(take_bits(4)), a);
      // both operand orders
      if (take_bits(1) != 0) begin
        issue_rs1 = a;
        issue_rs2 = b;
      end else begin
        issue_rs1 = b;
        issue_rs2 = a;
      end
      wb_ack = take_bits(2) != 0;
    end
    // idle with ack high so a duplicate would show up here
    @(negedge clk);
    issue_valid = 1'b0;
    wb_ack      = 1'b1;
    repeat (4) @(negedge clk);
    if (expected_q.size() == 0 && delivered == accepted) begin
      $display("Test passed");
      $finish;
    end else begin
      $display("accepted %0d items but wrote back %0d", accepted, delivered);
      fail_run();
    end
  end

endmodule
